/* Makefile */
TOP = tb_cached_mem

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter import cache_mem_pkg::*; (
    input logic I_clk,
    input logic arst_n,
    mem_bus_if.slave  load_bus,
    mem_bus_if.slave  store_bus,
    mem_bus_if.master mem_bus
);

    typedef enum logic [1:0] {
        NONE,
        LOAD,
        STORE
    } owner_t;

    owner_t owner;

    // the owner holds the bus until memory acknowledges, store wins a tie
    always_ff @(posedge I_clk or negedge arst_n) begin
        if (!arst_n) begin
            owner <= NONE;
        end else if (owner == NONE) begin
            if (store_bus.req) begin
                owner <= STORE;
            end else if (load_bus.req) begin
                owner <= LOAD;
            end
        end else if (mem_bus.ack) begin
            owner <= NONE;
        end
    end

    always_comb begin
        mem_bus.req     = 1'b0;
        mem_bus.op      = BUS_IDLE;
        mem_bus.addr    = '0;
        mem_bus.wdata   = '0;
        load_bus.ack    = 1'b0;
        load_bus.rdata  = '0;
        store_bus.ack   = 1'b0;
        store_bus.rdata = '0;
        case (owner)
            LOAD: begin
                mem_bus.req    = load_bus.req;
                mem_bus.op     = load_bus.op;
                mem_bus.addr   = load_bus.addr;
                mem_bus.wdata  = load_bus.wdata;
                load_bus.ack   = mem_bus.ack;
                load_bus.rdata = mem_bus.rdata;
            end
            STORE: begin
                mem_bus.req     = store_bus.req;
                mem_bus.op      = store_bus.op;
                mem_bus.addr    = store_bus.addr;
                mem_bus.wdata   = store_bus.wdata;
                store_bus.ack   = mem_bus.ack;
                store_bus.rdata = mem_bus.rdata;
            end
            default: begin
            end
        endcase
    end

endmodule

/* design/cache_mem_pkg.sv */
package cache_mem_pkg;

    // byte address on the memory bus
    typedef logic [15:0] addr_t;

    // one data word
    typedef logic [31:0] word_t;

    // word index into main memory, the byte address without its lane bits
    typedef logic [$bits(addr_t)-3:0] word_idx_t;

    typedef enum logic [2:0] {
        BUS_IDLE,
        BUS_READW,
        BUS_WRITEB,
        BUS_WRITEH,
        BUS_WRITEW
    } bus_op_t;

    // log2 of the number of cache entries
    localparam int DEF_ENTRY_BITS = 6;

    // cycles from grant to acknowledge in main memory
    localparam int DEF_MEM_LATENCY = 3;

    // bit 15 set selects the device region, which is never cached.
    // only aligned words below it may live in the cache
    function automatic logic cacheable_word(addr_t a);
        return (a[$bits(addr_t)-1] == 1'b0) && (a[1:0] == 2'b00);
    endfunction

endpackage

/* design/cached_mem_top.sv */
`timescale 1ns/1ps

module cached_mem_top import cache_mem_pkg::*; #(
    parameter int ENTRY_BITS  = DEF_ENTRY_BITS,
    parameter int MEM_LATENCY = DEF_MEM_LATENCY
) (
    input  logic    I_clk,
    input  logic    arst_n,
    input  logic    rd_req,
    input  addr_t   rd_addr,
    output logic    rd_busy,
    output logic    rd_valid,
    output word_t   rd_data,
    output logic    rd_hit,
    input  logic    wr_req,
    input  bus_op_t wr_op,
    input  addr_t   wr_addr,
    input  word_t   wr_data,
    output logic    wr_busy,
    output logic    wr_done,
    output logic    ready
);

    logic  lookup;
    addr_t lookup_addr;
    logic  fill;
    word_t fill_data;
    logic  hit;
    word_t hit_data;
    logic  inval;
    addr_t inval_addr;

    mem_bus_if load_bus ();
    mem_bus_if store_bus ();
    mem_bus_if mem_bus ();

    read_cache #(
        .ENTRY_BITS(ENTRY_BITS)
    ) read_cache_i (
        .I_clk       (I_clk),
        .arst_n      (arst_n),
        .lookup      (lookup),
        .lookup_addr (lookup_addr),
        .fill        (fill),
        .fill_data   (fill_data),
        .inval       (inval),
        .inval_addr  (inval_addr),
        .hit_data    (hit_data),
        .hit         (hit),
        .ready       (ready)
    );

    load_port load_port_i (
        .I_clk       (I_clk),
        .arst_n      (arst_n),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .ready       (ready),
        .hit         (hit),
        .hit_data    (hit_data),
        .rd_busy     (rd_busy),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .rd_hit      (rd_hit),
        .lookup      (lookup),
        .lookup_addr (lookup_addr),
        .fill        (fill),
        .fill_data   (fill_data),
        .bus         (load_bus.master)
    );

    store_port store_port_i (
        .I_clk      (I_clk),
        .arst_n     (arst_n),
        .wr_req     (wr_req),
        .wr_op      (wr_op),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .ready      (ready),
        .wr_busy    (wr_busy),
        .wr_done    (wr_done),
        .inval      (inval),
        .inval_addr (inval_addr),
        .bus        (store_bus.master)
    );

    bus_arbiter bus_arbiter_i (
        .I_clk     (I_clk),
        .arst_n    (arst_n),
        .load_bus  (load_bus.slave),
        .store_bus (store_bus.slave),
        .mem_bus   (mem_bus.master)
    );

    main_memory #(
        .MEM_LATENCY(MEM_LATENCY)
    ) main_memory_i (
        .I_clk  (I_clk),
        .arst_n (arst_n),
        .bus    (mem_bus.slave)
    );

endmodule

/* design/load_port.sv */
`timescale 1ns/1ps

module load_port import cache_mem_pkg::*; (
    input  logic  I_clk,
    input  logic  arst_n,
    input  logic  rd_req,
    input  addr_t rd_addr,
    input  logic  ready,
    input  logic  hit,
    input  word_t hit_data,
    output logic  rd_busy,
    output logic  rd_valid,
    output word_t rd_data,
    output logic  rd_hit,
    output logic  lookup,
    output addr_t lookup_addr,
    output logic  fill,
    output word_t fill_data,
    mem_bus_if.master bus
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        BUS,
        DONE
    } state_t;

    state_t state;
    logic   accept;
    logic   req_q;
    logic   hit_q;
    addr_t  addr_q;
    word_t  data_q;

    assign accept = rd_req && ready && (state == IDLE);

    // the lookup starts in the request cycle so a hit returns two cycles later
    assign lookup      = accept;
    assign lookup_addr = rd_addr;

    always_ff @(posedge I_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            req_q <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    hit_q <= hit;
                    if (hit) begin
                        state <= DONE;
                    end else begin
                        state <= BUS;
                        req_q <= 1'b1;
                    end
                end
                BUS: begin
                    if (bus.ack) begin
                        state <= DONE;
                        req_q <= 1'b0;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge I_clk) begin
        if (accept) begin
            addr_q <= rd_addr;
        end
        if ((state == LOOKUP) && hit) begin
            data_q <= hit_data;
        end else if ((state == BUS) && bus.ack) begin
            data_q <= bus.rdata;
        end
    end

    assign bus.req   = req_q;
    assign bus.op    = BUS_READW;
    assign bus.addr  = addr_q;
    assign bus.wdata = '0;

    assign rd_busy  = (state != IDLE);
    assign rd_valid = (state == DONE);
    assign rd_data  = data_q;
    assign rd_hit   = rd_valid && hit_q;

    // the cache takes any fill offered, so only aligned cacheable misses go in
    assign fill      = rd_valid && !hit_q && cacheable_word(addr_q);
    assign fill_data = data_q;

endmodule

/* design/main_memory.sv */
`timescale 1ns/1ps

module main_memory import cache_mem_pkg::*; #(
    parameter int MEM_LATENCY = DEF_MEM_LATENCY
) (
    input logic I_clk,
    input logic arst_n,
    mem_bus_if.slave bus
);

    localparam int MEM_WORDS = 2 ** $bits(word_idx_t);
    localparam int CNT_W     = $clog2(MEM_LATENCY) + 1;

    typedef logic [CNT_W-1:0] count_t;

    word_t     mem [MEM_WORDS];
    count_t    cnt;
    logic      fire;
    logic [3:0] lanes;
    word_idx_t widx;

    // word k starts out as c0de over its own index
    initial begin
        for (int k = 0; k < MEM_WORDS; k++) begin
            mem[k] = {16'hc0de, 16'(k)};
        end
    end

    assign widx = bus.addr[$bits(addr_t)-1:2];
    // the access happens on the last count, ack follows in the next cycle
    assign fire = bus.req && !bus.ack && (cnt == count_t'(MEM_LATENCY - 1));

    always_comb begin
        case (bus.op)
            BUS_WRITEB: lanes = 4'b0001 << bus.addr[1:0];
            BUS_WRITEH: lanes = bus.addr[1] ? 4'b1100 : 4'b0011;
            BUS_WRITEW: lanes = 4'b1111;
            default:    lanes = 4'b0000;
        endcase
    end

    always_ff @(posedge I_clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt     <= '0;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= fire;
            if (fire) begin
                cnt <= '0;
            end else if (bus.req && !bus.ack) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge I_clk) begin
        if (fire) begin
            bus.rdata <= mem[widx];
            for (int i = 0; i < 4; i++) begin
                if (lanes[i]) begin
                    mem[widx][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

/* design/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if import cache_mem_pkg::*; ();

    // request side, held steady by the master until ack
    logic    req;
    bus_op_t op;
    addr_t   addr;
    word_t   wdata;

    // response side, ack is a single cycle pulse and rdata is valid with it
    logic    ack;
    word_t   rdata;

    modport master (
        output req,
        output op,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    modport slave (
        input  req,
        input  op,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

/* design/read_cache.sv */
`timescale 1ns/1ps

module read_cache import cache_mem_pkg::*; #(
    parameter int ENTRY_BITS = DEF_ENTRY_BITS
) (
    input  logic  I_clk,
    input  logic  arst_n,
    input  logic  lookup,
    input  addr_t lookup_addr,
    input  logic  fill,
    input  word_t fill_data,
    input  logic  inval,
    input  addr_t inval_addr,
    output word_t hit_data,
    output logic  hit,
    output logic  ready
);

    localparam int ENTRIES  = 2 ** ENTRY_BITS;
    localparam int ADDR_MSB = $bits(addr_t) - 1;
    localparam int IDX_LO   = 2;
    localparam int IDX_HI   = IDX_LO + ENTRY_BITS - 1;
    localparam int TAG_W    = ADDR_MSB - IDX_HI;

    typedef logic [ENTRY_BITS-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;
    // a stored tag is the valid bit on top of the upper address bits
    typedef logic [TAG_W:0] tag_entry_t;

    typedef enum logic {
        CLEARING,
        RUN
    } state_t;

    state_t     state;
    index_t     clr_cnt;
    tag_entry_t tags [ENTRIES];
    word_t      data [ENTRIES];
    tag_entry_t tag_q;
    addr_t      addr_q;
    index_t     lookup_idx;
    index_t     fill_idx;
    index_t     inval_idx;
    tag_t       addr_q_tag;

    assign lookup_idx = lookup_addr[IDX_HI:IDX_LO];
    assign inval_idx  = inval_addr[IDX_HI:IDX_LO];
    // the fill always belongs to the last lookup, so its address indexes the fill
    assign fill_idx   = addr_q[IDX_HI:IDX_LO];
    assign addr_q_tag = addr_q[ADDR_MSB:IDX_HI+1];

    // after reset the counter walks every entry once, then the cache opens
    always_ff @(posedge I_clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= CLEARING;
            clr_cnt <= '0;
        end else if (state == CLEARING) begin
            clr_cnt <= clr_cnt + 1'b1;
            if (clr_cnt == index_t'(ENTRIES - 1)) begin
                state <= RUN;
            end
        end
    end

    assign ready = (state == RUN);

    always_ff @(posedge I_clk) begin
        if (state == CLEARING) begin
            tags[clr_cnt] <= '0;
        end else begin
            if (fill) begin
                tags[fill_idx] <= {1'b1, addr_q_tag};
                data[fill_idx] <= fill_data;
            end
            // written last so an invalidate beats a fill of the same entry
            if (inval) begin
                tags[inval_idx] <= '0;
            end
        end

        if (lookup) begin
            addr_q   <= lookup_addr;
            hit_data <= data[lookup_idx];
            // a write finishing in this cycle must not leave a stale hit behind
            if (inval && (inval_idx == lookup_idx)) begin
                tag_q <= '0;
            end else begin
                tag_q <= tags[lookup_idx];
            end
        end
    end

    assign hit = tag_q[TAG_W] && (tag_q[TAG_W-1:0] == addr_q_tag) && cacheable_word(addr_q);

endmodule

/* design/store_port.sv */
`timescale 1ns/1ps

module store_port import cache_mem_pkg::*; (
    input  logic    I_clk,
    input  logic    arst_n,
    input  logic    wr_req,
    input  bus_op_t wr_op,
    input  addr_t   wr_addr,
    input  word_t   wr_data,
    input  logic    ready,
    output logic    wr_busy,
    output logic    wr_done,
    output logic    inval,
    output addr_t   inval_addr,
    mem_bus_if.master bus
);

    typedef enum logic {
        IDLE,
        BUS
    } state_t;

    state_t  state;
    logic    write_op;
    logic    accept;
    word_t   wdata_lanes;
    bus_op_t op_q;
    addr_t   addr_q;
    word_t   data_q;

    assign write_op = (wr_op == BUS_WRITEB) || (wr_op == BUS_WRITEH) || (wr_op == BUS_WRITEW);
    assign accept   = wr_req && ready && write_op && (state == IDLE);

    // wr_data is right aligned, copy it into every lane so memory picks by address
    always_comb begin
        case (wr_op)
            BUS_WRITEB: wdata_lanes = {4{wr_data[7:0]}};
            BUS_WRITEH: wdata_lanes = {2{wr_data[15:0]}};
            default:    wdata_lanes = wr_data;
        endcase
    end

    always_ff @(posedge I_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else if (accept) begin
            state <= BUS;
        end else if ((state == BUS) && bus.ack) begin
            state <= IDLE;
        end
    end

    always_ff @(posedge I_clk) begin
        if (accept) begin
            op_q   <= wr_op;
            addr_q <= wr_addr;
            data_q <= wdata_lanes;
        end
    end

    assign bus.req   = (state == BUS);
    assign bus.op    = op_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = data_q;

    assign wr_busy = (state == BUS);
    // done and the cache invalidate share the acknowledge cycle
    assign wr_done    = bus.ack;
    assign inval      = bus.ack;
    assign inval_addr = addr_q;

endmodule

/* sim.f */
design/cache_mem_pkg.sv
design/mem_bus_if.sv
design/read_cache.sv
design/load_port.sv
design/store_port.sv
design/bus_arbiter.sv
design/main_memory.sv
design/cached_mem_top.sv
testbench/tb_cached_mem.sv

/* testbench/tb_cached_mem.sv */
`timescale 1ns/1ps

module tb_cached_mem import cache_mem_pkg::*; ();

    localparam int ENTRY_BITS  = 6;
    localparam int MEM_LATENCY = 3;
    localparam int TIMEOUT     = 200;
    localparam int HIT_LATENCY = 2;
    // request, lookup and bus request cycles, the memory count, then the return cycle
    localparam int MISS_LATENCY = 3 + MEM_LATENCY + 1;
    localparam int ENTRIES     = 1 << ENTRY_BITS;
    localparam int TAG_LO      = 2 + ENTRY_BITS;

    typedef struct {
        logic    is_write;
        bus_op_t op;
        addr_t   addr;
        word_t   data;
        logic    with_next;
    } row_t;

    logic    I_clk;
    logic    arst_n;
    logic    rd_req;
    addr_t   rd_addr;
    logic    rd_busy;
    logic    rd_valid;
    word_t   rd_data;
    logic    rd_hit;
    logic    wr_req;
    bus_op_t wr_op;
    addr_t   wr_addr;
    word_t   wr_data;
    logic    wr_busy;
    logic    wr_done;
    logic    ready;

    row_t                rows[$];
    word_t               mem_model [16384];
    logic                tag_valid [ENTRIES];
    logic [15-TAG_LO:0]  tag_hi [ENTRIES];
    int                  err_count;
    int                  timeout_count;

    cached_mem_top #(
        .ENTRY_BITS  (ENTRY_BITS),
        .MEM_LATENCY (MEM_LATENCY)
    ) cached_mem_top_i (
        .I_clk    (I_clk),
        .arst_n   (arst_n),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .rd_busy  (rd_busy),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .rd_hit   (rd_hit),
        .wr_req   (wr_req),
        .wr_op    (wr_op),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_busy  (wr_busy),
        .wr_done  (wr_done),
        .ready    (ready)
    );

    initial begin
        I_clk = 1'b0;
        forever #4 I_clk = ~I_clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic add_row(input logic is_write, input bus_op_t op, input addr_t a,
                           input logic with_next);
        row_t r;
        r.is_write  = is_write;
        r.op        = op;
        r.addr      = a;
        r.data      = is_write ? word_t'($urandom()) : '0;
        r.with_next = with_next;
        rows.push_back(r);
    endtask

    // the lookup happens in the request cycle, so a miss fills the model right away
    task automatic predict_read(input addr_t a, output word_t exp_data, output logic exp_hit);
        int   idx;
        logic cacheable;
        idx       = int'(a[TAG_LO-1:2]);
        cacheable = (a[15] == 1'b0) && (a[1:0] == 2'b00);
        exp_data  = mem_model[a[15:2]];
        exp_hit   = cacheable && tag_valid[idx] && (tag_hi[idx] == a[15:TAG_LO]);
        if (cacheable && !exp_hit) begin
            tag_valid[idx] = 1'b1;
            tag_hi[idx]    = a[15:TAG_LO];
        end
    endtask

    task automatic apply_write(input bus_op_t op, input addr_t a, input word_t d);
        int    lane;
        word_t w;
        lane = int'(a[1:0]);
        w    = mem_model[a[15:2]];
        case (op)
            BUS_WRITEB: w[8*lane +: 8] = d[7:0];
            BUS_WRITEH: w[16*(lane/2) +: 16] = d[15:0];
            default:    w = d;
        endcase
        mem_model[a[15:2]] = w;
        // every write drops its entry whatever tag it holds
        tag_valid[int'(a[TAG_LO-1:2])] = 1'b0;
    endtask

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        @(negedge I_clk);
        while ((rd_busy || wr_busy) && cnt < TIMEOUT) begin
            @(negedge I_clk);
            cnt++;
        end
        if (rd_busy || wr_busy) begin
            $display("ERROR at %0t ns: ports still busy after %0d cycles", $time, TIMEOUT);
            timeout_count++;
        end
    endtask

    // issues one row, or a read and a write together, and checks the results
    task automatic run_step(input int first, input int count);
        row_t    r;
        logic    want_rd;
        logic    want_wr;
        logic    rd_seen;
        logic    wr_seen;
        addr_t   ra;
        bus_op_t wop;
        addr_t   wa;
        word_t   wd;
        word_t   got_data;
        logic    got_hit;
        word_t   exp_data;
        logic    exp_hit;
        int      lat;
        int      cnt;
        want_rd = 1'b0;
        want_wr = 1'b0;
        wait_idle();
        @(posedge I_clk);
        for (int k = first; k < first + count; k++) begin
            r = rows[k];
            if (r.is_write) begin
                want_wr = 1'b1;
                wop     = r.op;
                wa      = r.addr;
                wd      = r.data;
                wr_req  <= 1'b1;
                wr_op   <= r.op;
                wr_addr <= r.addr;
                wr_data <= r.data;
            end else begin
                want_rd = 1'b1;
                ra      = r.addr;
                rd_req  <= 1'b1;
                rd_addr <= r.addr;
            end
        end
        if (want_rd) begin
            predict_read(ra, exp_data, exp_hit);
        end
        if (want_wr) begin
            apply_write(wop, wa, wd);
        end
        @(posedge I_clk);
        rd_req <= 1'b0;
        wr_req <= 1'b0;
        rd_seen = !want_rd;
        wr_seen = !want_wr;
        cnt = 1;
        while (!(rd_seen && wr_seen) && cnt <= TIMEOUT) begin
            @(negedge I_clk);
            if (rd_valid && !rd_seen) begin
                rd_seen  = 1'b1;
                got_data = rd_data;
                got_hit  = rd_hit;
                lat      = cnt;
            end
            if (wr_done) begin
                wr_seen = 1'b1;
            end
            cnt++;
        end
        if (!rd_seen) begin
            $display("ERROR at %0t ns: read of %h never returned rd_valid", $time, ra);
            timeout_count++;
        end else if (want_rd) begin
            check_value($sformatf("rd_data @%h", ra), got_data, exp_data);
            check_value($sformatf("rd_hit @%h", ra), 32'(got_hit), 32'(exp_hit));
            if (exp_hit) begin
                check_value($sformatf("rd_valid delay @%h", ra), lat, HIT_LATENCY);
            end else if (!want_wr) begin
                // a miss alone on the bus sees the memory latency and nothing else
                check_value($sformatf("rd_valid delay @%h", ra), lat, MISS_LATENCY);
            end
        end
        if (!wr_seen) begin
            $display("ERROR at %0t ns: write to %h never returned wr_done", $time, wa);
            timeout_count++;
        end
    endtask

    initial begin
        int i;
        int cnt;
        arst_n  = 1'b0;
        rd_req  = 1'b0;
        rd_addr = '0;
        wr_req  = 1'b0;
        wr_op   = BUS_IDLE;
        wr_addr = '0;
        wr_data = '0;
        err_count     = 0;
        timeout_count = 0;
        void'($urandom(32'h7cc891af));
        for (int k = 0; k < 16384; k++) begin
            mem_model[k] = {16'hc0de, 16'(k)};
        end
        for (int k = 0; k < ENTRIES; k++) begin
            tag_valid[k] = 1'b0;
            tag_hi[k]    = '0;
        end

        // cold miss, then a hit on the same word
        add_row(0, BUS_READW, 16'h0040, 0);
        add_row(0, BUS_READW, 16'h0040, 0);
        // each write size into a cached word, then miss and hit
        add_row(1, BUS_WRITEB, 16'h0041, 0);
        add_row(0, BUS_READW, 16'h0040, 0);
        add_row(0, BUS_READW, 16'h0040, 0);
        add_row(0, BUS_READW, 16'h0104, 0);
        add_row(1, BUS_WRITEH, 16'h0106, 0);
        add_row(0, BUS_READW, 16'h0104, 0);
        add_row(0, BUS_READW, 16'h0104, 0);
        add_row(0, BUS_READW, 16'h0208, 0);
        add_row(1, BUS_WRITEW, 16'h0208, 0);
        add_row(0, BUS_READW, 16'h0208, 0);
        add_row(0, BUS_READW, 16'h0208, 0);
        // device region and misaligned reads never hit
        add_row(0, BUS_READW, 16'h8040, 0);
        add_row(0, BUS_READW, 16'h8040, 0);
        add_row(1, BUS_WRITEB, 16'h8003, 0);
        add_row(0, BUS_READW, 16'h8000, 0);
        add_row(0, BUS_READW, 16'h0042, 0);
        add_row(0, BUS_READW, 16'h0042, 0);
        add_row(0, BUS_READW, 16'h0105, 0);
        // 0x0300 and 0x1300 share entry 0
        add_row(0, BUS_READW, 16'h0300, 0);
        add_row(0, BUS_READW, 16'h1300, 0);
        add_row(0, BUS_READW, 16'h0300, 0);
        add_row(0, BUS_READW, 16'h1300, 0);
        // pairs issued in one cycle, on different entries
        add_row(0, BUS_READW, 16'h0604, 1);
        add_row(1, BUS_WRITEW, 16'h0508, 0);
        add_row(0, BUS_READW, 16'h0508, 0);
        add_row(0, BUS_READW, 16'h0508, 0);
        add_row(1, BUS_WRITEH, 16'h0702, 1);
        add_row(0, BUS_READW, 16'h0040, 0);
        add_row(0, BUS_READW, 16'h0700, 0);

        repeat (4) @(posedge I_clk);
        @(negedge I_clk);
        check_value("outputs in reset", {rd_valid, rd_busy, wr_done, wr_busy, ready}, 0);
        @(posedge I_clk);
        arst_n <= 1'b1;

        // ready should rise one clearing sweep after the release
        cnt = 0;
        @(negedge I_clk);
        while (!ready && cnt < TIMEOUT) begin
            @(negedge I_clk);
            cnt++;
        end
        if (!ready) begin
            $display("ERROR at %0t ns: ready never rose after reset", $time);
            timeout_count++;
        end else begin
            check_value("ready delay", cnt, ENTRIES);
        end

        i = 0;
        while (i < rows.size()) begin
            if (rows[i].with_next && (i + 1 < rows.size())) begin
                run_step(i, 2);
                i += 2;
            end else begin
                run_step(i, 1);
                i += 1;
            end
        end

        $display("errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
